//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = rom_loader_tb
FILELIST = rom_loader_top.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir

//--- rom_loader_top.f
+incdir+tests
rtl/rom_loader_pkg.sv
rtl/download_assembler.sv
rtl/rom_bank_array.sv
rtl/rom_read_mux.sv
rtl/rom_loader_top.sv
tests/rom_loader_tb.sv

//--- rtl/download_assembler.sv
// Four-phase download receiver that pairs bytes into words and decodes the target bank
`timescale 1ns/1ps

module download_assembler
	import rom_loader_pkg::*;
#(
	parameter int DL_ADDR_W = 12,
	parameter int MAIN_ADDR_W = 6,
	parameter int SND_ADDR_W = 7
) (
	input logic clk_sys,
	input logic rst_n,
	input logic dl_req,
	input logic [DL_ADDR_W-1:0] dl_addr,
	input logic [7:0] dl_byte,
	output logic dl_ack,
	output dl_write_t wr
);

	// Region boundaries in byte addresses
	localparam int unsigned SND_BASE = main_region_bytes(MAIN_ADDR_W);
	localparam int unsigned SND_END = snd_region_end(MAIN_ADDR_W, SND_ADDR_W);

	logic [31:0] byte_addr;
	logic [31:0] snd_off;
	logic is_main;
	logic is_snd;
	logic accept;
	rom_bank_e dec_bank;
	logic [15:0] dec_addr;
	logic dec_en;
	logic [7:0] prev_byte;
	logic wr_valid;
	rom_bank_e wr_bank;
	logic [15:0] wr_addr;
	logic [15:0] wr_data;

	// ####################################################################
	// Address decode
	// ####################################################################

	assign byte_addr = 32'(dl_addr);
	assign snd_off = byte_addr - SND_BASE;
	assign is_main = byte_addr < SND_BASE;
	assign is_snd = !is_main && (byte_addr < SND_END);

	always_comb begin
		// Unmapped by default, nothing gets written
		dec_bank = BANK_NONE;
		dec_addr = '0;
		dec_en = 1'b0;
		if (is_main) begin
			// Two bits above the in-bank byte offset pick the main bank
			dec_bank = rom_bank_e'({1'b0, byte_addr[MAIN_ADDR_W+2 -: 2]});
			dec_addr = 16'(byte_addr[MAIN_ADDR_W:1]);
			// Word completes on the odd byte
			dec_en = byte_addr[0];
		end else if (is_snd) begin
			dec_bank = rom_bank_e'({2'b10, snd_off[SND_ADDR_W]});
			dec_addr = 16'(snd_off[SND_ADDR_W-1:0]);
			dec_en = 1'b1;
		end
	end

	// ####################################################################
	// Handshake and write issue
	// ####################################################################

	// New request seen while the ack is still low
	assign accept = dl_req && !dl_ack;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_ack <= 1'b0;
			wr_valid <= 1'b0;
		end else begin
			// Write pulse lines up with the rising ack
			wr_valid <= accept && dec_en;
			if (accept) begin
				dl_ack <= 1'b1;
			end else if (!dl_req) begin
				dl_ack <= 1'b0;
			end
		end
	end

	// Payload side, captured on every accepted byte
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			prev_byte <= dl_byte;
			wr_bank <= dec_bank;
			wr_addr <= dec_addr;
			// Earlier byte of the pair lands in the high half
			wr_data <= is_snd ? {8'h00, dl_byte} : {prev_byte, dl_byte};
		end
	end

	assign wr = '{valid: wr_valid, bank: wr_bank, addr: wr_addr, data: wr_data};

endmodule

//--- rtl/rom_bank_array.sv
// Main program and sound ROM storage, written by the loader and read by the board side
`timescale 1ns/1ps

module rom_bank_array
	import rom_loader_pkg::*;
#(
	parameter int MAIN_ADDR_W = 6,
	parameter int SND_ADDR_W = 7
) (
	input logic clk_sys,
	input dl_write_t wr,
	input logic [15:0] main_addr,
	input logic [15:0] snd_addr,
	output logic [MAIN_DATA_W-1:0] main_q [MAIN_BANKS],
	output logic [SND_DATA_W-1:0] snd_q [SND_BANKS]
);

	// Read indices, trimmed to each bank depth
	logic [MAIN_ADDR_W-1:0] main_rd_idx;
	logic [SND_ADDR_W-1:0] snd_rd_idx;

	// Write indices from the loader
	logic [MAIN_ADDR_W-1:0] main_wr_idx;
	logic [SND_ADDR_W-1:0] snd_wr_idx;

	assign main_rd_idx = main_addr[MAIN_ADDR_W-1:0];
	assign snd_rd_idx = snd_addr[SND_ADDR_W-1:0];
	assign main_wr_idx = wr.addr[MAIN_ADDR_W-1:0];
	assign snd_wr_idx = wr.addr[SND_ADDR_W-1:0];

	// ####################################################################
	// Main program banks: system, rom1, rom2, slap
	// ####################################################################

	for (genvar k = 0; k < MAIN_BANKS; k++) begin : g_main
		// Bank k answers to enum value k
		localparam rom_bank_e BANK_ID = rom_bank_e'(3'(k));

		logic [MAIN_DATA_W-1:0] mem [2**MAIN_ADDR_W];

		// Dual port block RAM style
		// loader port A, board port B
		always_ff @(posedge clk_sys) begin
			if (wr.valid && (wr.bank == BANK_ID)) begin
				mem[main_wr_idx] <= wr.data;
			end
			// Registered read, one cycle latency
			main_q[k] <= mem[main_rd_idx];
		end
	end

	// ####################################################################
	// Sound banks, byte wide
	// ####################################################################

	for (genvar j = 0; j < SND_BANKS; j++) begin : g_snd
		// Sound banks follow the main ones in the enum
		localparam rom_bank_e BANK_ID = rom_bank_e'(3'(int'(BANK_SND0) + j));

		logic [SND_DATA_W-1:0] mem [2**SND_ADDR_W];

		always_ff @(posedge clk_sys) begin
			// Only the low byte of the write word is meaningful here
			if (wr.valid && (wr.bank == BANK_ID)) begin
				mem[snd_wr_idx] <= wr.data[SND_DATA_W-1:0];
			end
			snd_q[j] <= mem[snd_rd_idx];
		end
	end

endmodule

//--- rtl/rom_loader_pkg.sv
// Shared types and region layout helpers for the ROM loader, imported by the RTL and testbench
package rom_loader_pkg;

	// ####################################################################
	// Bank geometry
	// ####################################################################

	// Main program banks are word wide, sound banks are byte wide
	localparam int MAIN_BANKS = 4;
	localparam int SND_BANKS = 2;
	localparam int MAIN_DATA_W = 16;
	localparam int SND_DATA_W = 8;

	// Write target, main banks first so the bank index casts straight in
	typedef enum logic [2:0] {
		BANK_SYSTEM = 3'd0,
		BANK_ROM1 = 3'd1,
		BANK_ROM2 = 3'd2,
		BANK_SLAP = 3'd3,
		BANK_SND0 = 3'd4,
		BANK_SND1 = 3'd5,
		BANK_NONE = 3'd7
	} rom_bank_e;

	// One assembled write toward the bank array
	typedef struct packed {
		logic valid;
		rom_bank_e bank;
		logic [15:0] addr;   // Word index, high bits unused for small banks
		logic [15:0] data;   // Sound writes carry the byte in the low half
	} dl_write_t;

	// Board side read requests, selects active low
	typedef struct packed {
		logic [MAIN_BANKS-1:0] sel_n;
		logic [15:0] addr;
	} main_rd_t;

	typedef struct packed {
		logic [SND_BANKS-1:0] sel_n;
		logic [15:0] addr;
	} snd_rd_t;

	// ####################################################################
	// Download region layout
	// ####################################################################

	// Each main bank spans two bytes per word
	function automatic int unsigned main_bank_bytes(input int unsigned main_addr_w);
		return 32'd1 << (main_addr_w + 1);
	endfunction

	// Sound banks start right after the main region
	function automatic int unsigned main_region_bytes(input int unsigned main_addr_w);
		return MAIN_BANKS * main_bank_bytes(main_addr_w);
	endfunction

	function automatic int unsigned snd_bank_bytes(input int unsigned snd_addr_w);
		return 32'd1 << snd_addr_w;
	endfunction

	// First unmapped byte address
	function automatic int unsigned snd_region_end(input int unsigned main_addr_w,
			input int unsigned snd_addr_w);
		return main_region_bytes(main_addr_w) + SND_BANKS * snd_bank_bytes(snd_addr_w);
	endfunction

endpackage

//--- rtl/rom_loader_top.sv
// Top level of the ROM download path, wiring the assembler, bank storage and read mux
`timescale 1ns/1ps

module rom_loader_top
	import rom_loader_pkg::*;
#(
	parameter int MAIN_ADDR_W = 6,
	parameter int SND_ADDR_W = 7,
	parameter int DL_ADDR_W = 12
) (
	input logic clk_sys,
	input logic rst_n,
	// Host download port, four-phase req/ack
	input logic dl_req,
	input logic [DL_ADDR_W-1:0] dl_addr,
	input logic [7:0] dl_byte,
	output logic dl_ack,
	// Board side reads
	input main_rd_t main_rd,
	input snd_rd_t snd_rd,
	output logic [MAIN_DATA_W-1:0] main_data,
	output logic [SND_DATA_W-1:0] snd_data
);

	dl_write_t wr;
	logic [MAIN_DATA_W-1:0] main_q [MAIN_BANKS];
	logic [SND_DATA_W-1:0] snd_q [SND_BANKS];

	// Input side
	download_assembler #(
		.DL_ADDR_W(DL_ADDR_W),
		.MAIN_ADDR_W(MAIN_ADDR_W),
		.SND_ADDR_W(SND_ADDR_W)
	) u_assembler (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.dl_req(dl_req),
		.dl_addr(dl_addr),
		.dl_byte(dl_byte),
		.dl_ack(dl_ack),
		.wr(wr)
	);

	// Storage, addresses come straight from the read structs
	rom_bank_array #(
		.MAIN_ADDR_W(MAIN_ADDR_W),
		.SND_ADDR_W(SND_ADDR_W)
	) u_banks (
		.clk_sys(clk_sys),
		.wr(wr),
		.main_addr(main_rd.addr),
		.snd_addr(snd_rd.addr),
		.main_q(main_q),
		.snd_q(snd_q)
	);

	// Output side gets the selects
	rom_read_mux u_mux (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.main_sel_n(main_rd.sel_n),
		.snd_sel_n(snd_rd.sel_n),
		.main_q(main_q),
		.snd_q(snd_q),
		.main_data(main_data),
		.snd_data(snd_data)
	);

endmodule

//--- rtl/rom_read_mux.sv
// Priority read mux turning the active-low bank selects into main and sound data words
`timescale 1ns/1ps

module rom_read_mux
	import rom_loader_pkg::*;
(
	input logic clk_sys,
	input logic rst_n,
	input logic [MAIN_BANKS-1:0] main_sel_n,
	input logic [SND_BANKS-1:0] snd_sel_n,
	input logic [MAIN_DATA_W-1:0] main_q [MAIN_BANKS],
	input logic [SND_DATA_W-1:0] snd_q [SND_BANKS],
	output logic [MAIN_DATA_W-1:0] main_data,
	output logic [SND_DATA_W-1:0] snd_data
);

	// Selects delayed to match the registered memory read
	logic [MAIN_BANKS-1:0] main_sel_q;
	logic [SND_BANKS-1:0] snd_sel_q;

	// ####################################################################
	// Select pipeline
	// ####################################################################

	// All ones means nothing selected, so outputs sit at zero after reset
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			main_sel_q <= '1;
			snd_sel_q <= '1;
		end else begin
			main_sel_q <= main_sel_n;
			snd_sel_q <= snd_sel_n;
		end
	end

	// ####################################################################
	// Priority selection
	// ####################################################################

	// Walk from the highest bank down
	// the lowest active select is applied last and wins
	always_comb begin
		main_data = '0;
		for (int i = MAIN_BANKS - 1; i >= 0; i--) begin
			if (!main_sel_q[i]) begin
				main_data = main_q[i];
			end
		end
	end

	// Same ordering for sound, snd0 ahead of snd1
	always_comb begin
		snd_data = '0;
		for (int i = SND_BANKS - 1; i >= 0; i--) begin
			if (!snd_sel_q[i]) begin
				snd_data = snd_q[i];
			end
		end
	end

endmodule

//--- tests/rom_loader_model.svh
// Reference bank contents and host download tasks, included into the ROM loader testbench

// Expected memory contents with one array per bank group
logic [15:0] main_mem [MAIN_BANKS][MAIN_WORDS];
logic [7:0] snd_mem [SND_BANKS][SND_BANK_BYTES];
// Last byte sent becomes the high half of the next main word
logic [7:0] last_byte = 8'h00;

// Apply one downloaded byte to the model by the region layout rule
function automatic void model_write(input int addr, input logic [7:0] b);
	int off;
	if (addr < SND_BASE) begin
		off = addr % MAIN_BANK_BYTES;
		// Main word completes on the odd byte
		if (off % 2 == 1) begin
			main_mem[addr / MAIN_BANK_BYTES][off / 2] = {last_byte, b};
		end
	end else if (addr < SND_END) begin
		off = addr - SND_BASE;
		snd_mem[off / SND_BANK_BYTES][off % SND_BANK_BYTES] = b;
	end
	// Unmapped bytes still move the pairing register
	last_byte = b;
endfunction

// Lowest numbered active select wins and zero comes out when none is active
function automatic logic [15:0] expect_main(input main_rd_t r);
	for (int i = 0; i < MAIN_BANKS; i++) begin
		if (!r.sel_n[i]) begin
			return main_mem[i][r.addr[MAIN_ADDR_W-1:0]];
		end
	end
	return '0;
endfunction

function automatic logic [7:0] expect_snd(input snd_rd_t r);
	for (int i = 0; i < SND_BANKS; i++) begin
		if (!r.sel_n[i]) begin
			return snd_mem[i][r.addr[SND_ADDR_W-1:0]];
		end
	end
	return '0;
endfunction

// Four-phase transfer of one byte where each ack edge must come within 4 cycles
task automatic send_byte(input int addr, input logic [7:0] b);
	int waits;
	@(posedge clk_sys);
	#2;
	assert (dl_ack == 1'b0) else begin
		$display("dl_ack was still high when a new request was due");
		abort_run();
	end
	dl_addr = DL_ADDR_W'(addr);
	dl_byte = b;
	dl_req = 1'b1;
	waits = 0;
	while (!dl_ack) begin
		@(negedge clk_sys);
		waits++;
		assert (waits <= 4) else begin
			$display("dl_ack did not rise within 4 cycles of dl_req");
			abort_run();
		end
	end
	@(posedge clk_sys);
	#2;
	// Ack has to hold until the host drops the request
	assert (dl_ack == 1'b1) else begin
		$display("dl_ack fell while dl_req was still high");
		abort_run();
	end
	dl_req = 1'b0;
	model_write(addr, b);
	waits = 0;
	while (dl_ack) begin
		@(negedge clk_sys);
		waits++;
		assert (waits <= 4) else begin
			$display("dl_ack did not fall within 4 cycles of dl_req dropping");
			abort_run();
		end
	end
endtask

//--- tests/rom_loader_tb.sv
// Self-checking testbench for the ROM loader, run through the Makefile with Verilator
`timescale 1ns/1ps

module rom_loader_tb
	import rom_loader_pkg::*;
;

	localparam int MAIN_ADDR_W = 6;
	localparam int SND_ADDR_W = 7;
	localparam int DL_ADDR_W = 12;

	// Layout worked out from the region rule
	localparam int MAIN_WORDS = 2 ** MAIN_ADDR_W;
	localparam int MAIN_BANK_BYTES = 2 * MAIN_WORDS;
	localparam int SND_BASE = MAIN_BANKS * MAIN_BANK_BYTES;
	localparam int SND_BANK_BYTES = 2 ** SND_ADDR_W;
	localparam int SND_END = SND_BASE + SND_BANKS * SND_BANK_BYTES;

	// Run length sets the timeout
	localparam int N_UNMAP = 64;
	localparam int N_PRIO = 64;
	localparam int N_PIPE = 200;
	localparam int N_BYTES = SND_END + N_UNMAP;
	localparam int N_READS = 2 * (MAIN_BANKS * MAIN_WORDS + SND_BANKS * SND_BANK_BYTES)
		+ N_PRIO + N_PIPE;
	localparam int TIMEOUT = N_BYTES * 8 + N_READS + 100;

	logic clk_sys;
	logic rst_n;
	logic dl_req;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [7:0] dl_byte;
	logic dl_ack;
	main_rd_t main_rd;
	snd_rd_t snd_rd;
	logic [15:0] main_data;
	logic [7:0] snd_data;

	integer seed;
	int cycle_count = 0;

	// Request from one cycle back is checked against the output in the next cycle
	logic pend_valid = 1'b0;
	string pend_name;
	logic [15:0] pend_main;
	logic [7:0] pend_snd;

	rom_loader_top #(
		.MAIN_ADDR_W(MAIN_ADDR_W),
		.SND_ADDR_W(SND_ADDR_W),
		.DL_ADDR_W(DL_ADDR_W)
	) rom_loader_top_i (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.dl_req(dl_req),
		.dl_addr(dl_addr),
		.dl_byte(dl_byte),
		.dl_ack(dl_ack),
		.main_rd(main_rd),
		.snd_rd(snd_rd),
		.main_data(main_data),
		.snd_data(snd_data)
	);

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "stopping at the first error");
	endtask

	`include "rom_loader_model.svh"

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	function automatic main_rd_t main_req(input logic [MAIN_BANKS-1:0] sel_n, input int addr);
		main_rd_t r;
		r.sel_n = sel_n;
		r.addr = 16'(addr);
		return r;
	endfunction

	function automatic snd_rd_t snd_req(input logic [SND_BANKS-1:0] sel_n, input int addr);
		snd_rd_t r;
		r.sel_n = sel_n;
		r.addr = 16'(addr);
		return r;
	endfunction

	// ######################################################################
	// Read pipeline, one request per cycle
	// ######################################################################

	task automatic read_step(input string name, input main_rd_t m, input snd_rd_t s);
		@(posedge clk_sys);
		#2;
		main_rd = m;
		snd_rd = s;
		// Outputs now hold the request driven one cycle earlier
		@(negedge clk_sys);
		if (pend_valid) begin
			check_value(pend_name, pend_main, main_data);
			check_value(pend_name, {8'h00, pend_snd}, {8'h00, snd_data});
		end
		pend_valid = 1'b1;
		pend_name = name;
		pend_main = expect_main(m);
		pend_snd = expect_snd(s);
	endtask

	// Idle request drains the last pending check
	task automatic flush_reads(input string name);
		read_step(name, main_req('1, 0), snd_req('1, 0));
		pend_valid = 1'b0;
	endtask

	task automatic read_main_banks(input string name);
		for (int k = 0; k < MAIN_BANKS; k++) begin
			for (int w = 0; w < MAIN_WORDS; w++) begin
				read_step(name, main_req(MAIN_BANKS'(~(1 << k)), w), snd_req('1, 0));
			end
		end
		flush_reads(name);
	endtask

	task automatic read_snd_banks(input string name);
		for (int j = 0; j < SND_BANKS; j++) begin
			for (int b = 0; b < SND_BANK_BYTES; b++) begin
				read_step(name, main_req('1, 0), snd_req(SND_BANKS'(~(1 << j)), b));
			end
		end
		flush_reads(name);
	endtask

	// ######################################################################
	// Clock, timeout and test sequence
	// ######################################################################

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		assert (cycle_count < TIMEOUT) else begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_count);
			abort_run();
		end
	end

	initial begin
		logic [MAIN_BANKS-1:0] ms;
		logic [SND_BANKS-1:0] ss;
		int r;
		seed = 71;
		rst_n = 1'b0;
		dl_req = 1'b0;
		dl_addr = '0;
		dl_byte = '0;
		// All selects active during reset so only the select pipeline reset keeps outputs at zero
		main_rd = main_req('0, 0);
		snd_rd = snd_req('0, 0);
		repeat (4) @(posedge clk_sys);
		#2;
		rst_n = 1'b1;
		@(negedge clk_sys);
		assert (dl_ack == 1'b0) else begin
			$display("dl_ack is not low after reset");
			abort_run();
		end
		check_value("reset", 16'h0000, main_data);
		check_value("reset", 16'h0000, {8'h00, snd_data});
		@(posedge clk_sys);
		#2;
		main_rd = main_req('1, 0);
		snd_rd = snd_req('1, 0);

		// Whole main region in byte order so pairs stay even then odd
		for (int a = 0; a < SND_BASE; a++) begin
			send_byte(a, 8'($random(seed)));
		end
		read_main_banks("main_load");

		for (int a = SND_BASE; a < SND_END; a++) begin
			send_byte(a, 8'($random(seed)));
		end
		read_snd_banks("snd_load");

		// Every eighth pattern has nothing selected
		for (int i = 0; i < N_PRIO; i++) begin
			ms = MAIN_BANKS'($random(seed));
			ss = SND_BANKS'($random(seed));
			if (i % 8 == 0) begin
				ms = '1;
				ss = '1;
			end
			read_step("priority", main_req(ms, $random(seed) & (MAIN_WORDS - 1)),
				snd_req(ss, $random(seed) & (SND_BANK_BYTES - 1)));
		end
		flush_reads("priority");

		// Above the sound region nothing may change
		for (int i = 0; i < N_UNMAP; i++) begin
			r = $random(seed);
			send_byte(SND_END + ((r & 32'h7fff_ffff) % (2 ** DL_ADDR_W - SND_END)),
				8'($random(seed)));
		end
		read_main_banks("unmapped");
		read_snd_banks("unmapped");

		// Back to back random requests
		for (int i = 0; i < N_PIPE; i++) begin
			read_step("pipelined",
				main_req(MAIN_BANKS'($random(seed)), $random(seed) & (MAIN_WORDS - 1)),
				snd_req(SND_BANKS'($random(seed)), $random(seed) & (SND_BANK_BYTES - 1)));
		end
		flush_reads("pipelined");

		$display("Everything OK");
		$finish;
	end

endmodule
